/* verilog/rt_pkg.sv */
// ##################################################################
// Shared widths and packed struct types of the register-dependency
// table: entries, insert and write-back strobes, operand results
// ##################################################################

package rt_pkg;

    // ##################################################################
    // Widths and counts
    // ##################################################################

    // Producer tag, at most 8 instructions in flight
    localparam int unsigned tag_w = 3;
    localparam int unsigned reg_idx_w = 5;
    localparam int unsigned subwarp_w = 2;

    // Source operands per instruction
    localparam int unsigned num_operands = 2;
    // Write-back ports from the execution units
    localparam int unsigned num_wb = 2;

    typedef logic [tag_w-1:0] tag_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [subwarp_w-1:0] subwarp_id_t;

    // ##################################################################
    // Table and port types
    // ##################################################################

    // One table entry, register of a subwarp and its pending producer
    typedef struct packed {
        subwarp_id_t subwarp_id;
        reg_idx_t dst;
        tag_t producer;
    } rt_entry_t;

    // Decoded instruction from the decoder
    typedef struct packed {
        logic strobe;
        subwarp_id_t subwarp_id;
        tag_t tag;
        reg_idx_t dst;
        // Source operand registers, index 0 is the first operand
        reg_idx_t [num_operands-1:0] src;
    } rt_insert_t;

    // Completion of one tag on a write-back port
    typedef struct packed {
        logic strobe;
        tag_t tag;
    } rt_wb_t;

    // Readiness of one source operand
    typedef struct packed {
        logic ready;
        // Producer to wait for, zero when nothing is pending
        tag_t tag;
    } rt_operand_t;

endpackage

/* verilog/rt_alloc_ctrl.sv */
// ##################################################################
// Insert control: reuse or first-free allocation, write-back clear
// mask and the all-written flag
// ##################################################################

`timescale 1ns/100ps

module rt_alloc_ctrl #(
    parameter int unsigned num_tags = 8
) (
    input logic clk_i,
    input logic rst_i,

    // Decoder insert and execution unit write-backs
    input rt_pkg::rt_insert_t insert_i,
    input rt_pkg::rt_wb_t [rt_pkg::num_wb-1:0] wb_i,

    // Current table state from the store
    input logic [num_tags-1:0] valid_i,
    input rt_pkg::rt_entry_t [num_tags-1:0] entries_i,

    // Update command to the store
    output logic [num_tags-1:0] clear_o,
    output logic wr_en_o,
    output logic [$clog2(num_tags)-1:0] wr_idx_o,
    output rt_pkg::rt_entry_t wr_entry_o,

    // No entry live
    output logic all_dst_written_o
);

    import rt_pkg::*;

    localparam int unsigned idx_w = $clog2(num_tags);

    // Live entry with the same destination and subwarp
    logic match_found;
    logic [idx_w-1:0] match_idx;

    // Lowest free entry
    logic free_found;
    logic [idx_w-1:0] free_idx;

    // ##################################################################
    // Destination search
    // ##################################################################

    always_comb begin
        match_found = 1'b0;
        match_idx = '0;
        free_found = 1'b0;
        free_idx = '0;

        // First live entry for this destination of the subwarp
        for (int i = 0; i < num_tags; i++) begin
            if (!match_found && valid_i[i]
                && entries_i[i].dst == insert_i.dst
                && entries_i[i].subwarp_id == insert_i.subwarp_id) begin
                match_found = 1'b1;
                match_idx = idx_w'(i);
            end
        end

        // Lowest index that is not live
        // Entries freed in this cycle still count as taken
        for (int i = 0; i < num_tags; i++) begin
            if (!free_found && !valid_i[i]) begin
                free_found = 1'b1;
                free_idx = idx_w'(i);
            end
        end
    end

    // Reuse takes the matching entry, else allocate
    assign wr_en_o = insert_i.strobe && (match_found || free_found);
    assign wr_idx_o = match_found ? match_idx : free_idx;

    // On reuse dst and subwarp are unchanged, only producer moves on
    assign wr_entry_o = '{
        subwarp_id: insert_i.subwarp_id,
        dst: insert_i.dst,
        producer: insert_i.tag
    };

    // ##################################################################
    // Write-back clear
    // ##################################################################

    // Free every live entry produced by a completing tag
    always_comb begin
        clear_o = '0;
        for (int w = 0; w < num_wb; w++) begin
            for (int i = 0; i < num_tags; i++) begin
                if (wb_i[w].strobe && valid_i[i]
                    && entries_i[i].producer == wb_i[w].tag) begin
                    clear_o[i] = 1'b1;
                end
            end
        end
    end

    // Valid bits are registered, so this follows the table by one edge
    assign all_dst_written_o = ~|valid_i;

    // The decoder must never insert into a full table without reuse
    assert property (@(posedge clk_i) disable iff (rst_i)
        insert_i.strobe |-> (match_found || free_found))
    else $error("Insert of tag %0d finds no matching and no free entry", insert_i.tag);

endmodule

/* verilog/rt_entry_store.sv */
// ##################################################################
// Entry registers and valid bits with clear and single write
// ##################################################################

`timescale 1ns/100ps

module rt_entry_store #(
    parameter int unsigned num_tags = 8
) (
    input logic clk_i,
    input logic rst_i,

    // Entries freed by write-back
    input logic [num_tags-1:0] clear_i,

    // One insert write per cycle
    input logic wr_en_i,
    input logic [$clog2(num_tags)-1:0] wr_idx_i,
    input rt_pkg::rt_entry_t wr_entry_i,

    // Registered table state
    output logic [num_tags-1:0] valid_o,
    output rt_pkg::rt_entry_t [num_tags-1:0] entries_o
);

    import rt_pkg::*;

    logic [num_tags-1:0] valid_q;
    logic [num_tags-1:0] valid_d;
    rt_entry_t [num_tags-1:0] entries_q;

    // ##################################################################
    // Valid bits
    // ##################################################################

    always_comb begin
        // Clears first
        valid_d = valid_q & ~clear_i;
        // Write wins, so a reused entry stays live through its own free
        if (wr_en_i) begin
            valid_d[wr_idx_i] = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    // ##################################################################
    // Entry payload
    // ##################################################################

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            entries_q[wr_idx_i] <= wr_entry_i;
        end
    end

    assign valid_o = valid_q;
    assign entries_o = entries_q;

    // Reuse in the control keeps each register of a subwarp in one entry
    for (genvar i = 0; i < num_tags; i++) begin : g_uniq_a
        for (genvar j = i + 1; j < num_tags; j++) begin : g_uniq_b
            assert property (@(posedge clk_i) disable iff (rst_i)
                (valid_q[i] && valid_q[j])
                |-> (entries_q[i].dst != entries_q[j].dst
                     || entries_q[i].subwarp_id != entries_q[j].subwarp_id))
            else $error("Entries %0d and %0d both hold register %0d", i, j,
                entries_q[i].dst);
        end
    end

endmodule

/* verilog/rt_operand_lookup.sv */
// ##################################################################
// Source operand readiness lookup with same-cycle write-back bypass
// ##################################################################

`timescale 1ns/100ps

module rt_operand_lookup #(
    parameter int unsigned num_tags = 8
) (
    // Only samples the bypass check
    input logic clk_i,

    // Operand registers and subwarp of the instruction being inserted
    input rt_pkg::rt_insert_t insert_i,
    input rt_pkg::rt_wb_t [rt_pkg::num_wb-1:0] wb_i,

    // Registered table state
    input logic [num_tags-1:0] valid_i,
    input rt_pkg::rt_entry_t [num_tags-1:0] entries_i,

    // One result per source operand
    output rt_pkg::rt_operand_t [rt_pkg::num_operands-1:0] operands_o
);

    import rt_pkg::*;

    // Operand found pending in the table
    logic [num_operands-1:0] hit;

    // ##################################################################
    // Per-operand search
    // ##################################################################

    always_comb begin
        hit = '0;
        for (int op = 0; op < num_operands; op++) begin
            // Ready with tag zero unless a live producer is found
            operands_o[op].ready = 1'b1;
            operands_o[op].tag = '0;

            // Only meaningful while an insert is on the bus
            if (insert_i.strobe) begin
                for (int i = 0; i < num_tags; i++) begin
                    if (!hit[op] && valid_i[i]
                        && entries_i[i].dst == insert_i.src[op]
                        && entries_i[i].subwarp_id == insert_i.subwarp_id) begin
                        hit[op] = 1'b1;
                        operands_o[op].ready = 1'b0;
                        operands_o[op].tag = entries_i[i].producer;
                    end
                end
            end

            // Producer completes now, value reaches the register file
            // The tag is kept for the wait buffer
            for (int w = 0; w < num_wb; w++) begin
                if (hit[op] && wb_i[w].strobe
                    && wb_i[w].tag == operands_o[op].tag) begin
                    operands_o[op].ready = 1'b1;
                end
            end
        end
    end

    // ##################################################################
    // Checks
    // ##################################################################

    // A live producer of the operand that completes now never leaves it waiting
    for (genvar op = 0; op < num_operands; op++) begin : g_op_chk
        for (genvar w = 0; w < num_wb; w++) begin : g_wb_chk
            for (genvar i = 0; i < num_tags; i++) begin : g_ent_chk
                assert property (@(posedge clk_i)
                    (insert_i.strobe && wb_i[w].strobe && valid_i[i]
                     && entries_i[i].dst == insert_i.src[op]
                     && entries_i[i].subwarp_id == insert_i.subwarp_id
                     && entries_i[i].producer == wb_i[w].tag)
                    |-> (operands_o[op].ready && operands_o[op].tag == wb_i[w].tag))
                else $error("Operand %0d waits on tag %0d written back on port %0d",
                    op, operands_o[op].tag, w);
            end
        end
    end

endmodule

/* verilog/reg_table_top.sv */
// ##################################################################
// Register-dependency table top: control, entry store and lookup
// ##################################################################

`timescale 1ns/100ps

module reg_table_top #(
    // Entries in the table, at most one per tag
    parameter int unsigned num_tags = 8
) (
    input logic clk_i,
    input logic rst_i,

    // From the decoder
    input rt_pkg::rt_insert_t insert_i,
    // From the execution units
    input rt_pkg::rt_wb_t [rt_pkg::num_wb-1:0] wb_i,

    // To the wait buffer
    output rt_pkg::rt_operand_t [rt_pkg::num_operands-1:0] operands_o,
    // To the fetcher, no pending destination
    output logic all_dst_written_o
);

    import rt_pkg::*;

    // Registered table state
    logic [num_tags-1:0] valid;
    rt_entry_t [num_tags-1:0] entries;

    // Update command from control to store
    logic [num_tags-1:0] clear;
    logic wr_en;
    logic [$clog2(num_tags)-1:0] wr_idx;
    rt_entry_t wr_entry;

    rt_alloc_ctrl #(
        .num_tags(num_tags)
    ) u_ctrl (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .insert_i(insert_i),
        .wb_i(wb_i),
        .valid_i(valid),
        .entries_i(entries),
        .clear_o(clear),
        .wr_en_o(wr_en),
        .wr_idx_o(wr_idx),
        .wr_entry_o(wr_entry),
        .all_dst_written_o(all_dst_written_o)
    );

    rt_entry_store #(
        .num_tags(num_tags)
    ) u_store (
        .clk_i(clk_i),
        .rst_i(rst_i),
        .clear_i(clear),
        .wr_en_i(wr_en),
        .wr_idx_i(wr_idx),
        .wr_entry_i(wr_entry),
        .valid_o(valid),
        .entries_o(entries)
    );

    // Readiness sees the table before this cycle's update
    rt_operand_lookup #(
        .num_tags(num_tags)
    ) u_lookup (
        .clk_i(clk_i),
        .insert_i(insert_i),
        .wb_i(wb_i),
        .valid_i(valid),
        .entries_i(entries),
        .operands_o(operands_o)
    );

endmodule

/* test/tb_rt_model.svh */
// ##################################################################
// Reference model of the table: pending tag per subwarp and register,
// and the pool of free and in-flight tags
// ##################################################################

`ifndef TB_RT_MODEL_SVH
`define TB_RT_MODEL_SVH

localparam int unsigned model_sws = 1 << subwarp_w;
localparam int unsigned model_regs = 1 << reg_idx_w;
localparam int unsigned model_tags = 1 << tag_w;

// Pending producer per subwarp and register
logic pend_valid [model_sws][model_regs];
tag_t pend_tag [model_sws][model_regs];

// Map slots in use, one per live table entry
int unsigned live_slots;

// Tags free to issue
tag_t free_tags [$];
// Tags issued and not yet written back
tag_t busy_tags [$];

// Empty map, every tag free
function automatic void reset_model();
    live_slots = 0;
    free_tags.delete();
    busy_tags.delete();
    for (int s = 0; s < model_sws; s++) begin
        for (int r = 0; r < model_regs; r++) begin
            pend_valid[s][r] = 1'b0;
            pend_tag[s][r] = '0;
        end
    end
    for (int t = 0; t < model_tags; t++) begin
        free_tags.push_back(tag_t'(t));
    end
endfunction

// Oldest free tag goes in flight
function automatic tag_t issue_tag();
    tag_t t;
    t = free_tags.pop_front();
    busy_tags.push_back(t);
    return t;
endfunction

// Completion frees every slot the tag still holds
function automatic void retire_tag(input tag_t t);
    for (int s = 0; s < model_sws; s++) begin
        for (int r = 0; r < model_regs; r++) begin
            if (pend_valid[s][r] && pend_tag[s][r] == t) begin
                pend_valid[s][r] = 1'b0;
                live_slots--;
            end
        end
    end
    for (int i = 0; i < busy_tags.size(); i++) begin
        if (busy_tags[i] == t) begin
            busy_tags.delete(i);
            break;
        end
    end
    free_tags.push_back(t);
endfunction

// Newest producer of a register, a new slot only when none was pending
function automatic void record_insert(input subwarp_id_t sw, input reg_idx_t dst,
                                      input tag_t t);
    if (!pend_valid[sw][dst]) begin
        live_slots++;
    end
    pend_valid[sw][dst] = 1'b1;
    pend_tag[sw][dst] = t;
endfunction

`endif

/* test/tb_reg_table.sv */
// ##################################################################
// Testbench of the register-dependency table: clock, reset, directed
// and random inserts and write-backs, checking assertions
// ##################################################################

`timescale 1ns/100ps

module tb_reg_table;

    import rt_pkg::*;

    localparam int unsigned num_tags = 8;
    // Random insert and write-back cycles
    localparam int unsigned num_random = 400;
    // Cycles allowed for the drain and for the empty flag
    localparam int unsigned drain_limit = 32;

    typedef rt_wb_t [num_wb-1:0] wb_bus_t;

    logic clk;
    logic rst;
    rt_insert_t insert;
    wb_bus_t wb;
    rt_operand_t [num_operands-1:0] operands;
    logic all_written;

    // Expected outputs for the cycle now on the bus
    logic exp_empty;
    rt_operand_t [num_operands-1:0] exp_operands;

    integer seed;

    `include "tb_rt_model.svh"

    reg_table_top #(
        .num_tags(num_tags)
    ) u_dut (
        .clk_i(clk),
        .rst_i(rst),
        .insert_i(insert),
        .wb_i(wb),
        .operands_o(operands),
        .all_dst_written_o(all_written)
    );

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // ##################################################################
    // Checks at the DUT ports
    // ##################################################################

    assert property (@(posedge clk) disable iff (rst) all_written == exp_empty)
    else abort_run($sformatf("Fail at %0d ns: all_dst_written_o is %0b, expected %0b",
        $time, $sampled(all_written), $sampled(exp_empty)));

    for (genvar op = 0; op < num_operands; op++) begin : g_op_chk
        assert property (@(posedge clk) disable iff (rst) operands[op] == exp_operands[op])
        else abort_run($sformatf(
            "Fail at %0d ns: operand %0d ready %0b tag %0d, expected ready %0b tag %0d",
            $time, op, $sampled(operands[op].ready), $sampled(operands[op].tag),
            $sampled(exp_operands[op].ready), $sampled(exp_operands[op].tag)));
    end

    // ##################################################################
    // Stimulus
    // ##################################################################

    function automatic rt_insert_t make_insert(input subwarp_id_t sw, input reg_idx_t dst,
                                               input tag_t t, input reg_idx_t src0,
                                               input reg_idx_t src1);
        rt_insert_t ins;
        ins.strobe = 1'b1;
        ins.subwarp_id = sw;
        ins.tag = t;
        ins.dst = dst;
        ins.src[0] = src0;
        ins.src[1] = src1;
        return ins;
    endfunction

    // Single completion on port 0
    function automatic wb_bus_t wb_single(input tag_t t);
        wb_bus_t wbs;
        wbs = '0;
        wbs[0] = '{strobe: 1'b1, tag: t};
        return wbs;
    endfunction

    // Drive one cycle, set its expected outputs, then advance the model
    task automatic step(input rt_insert_t ins, input wb_bus_t wbs);
        tag_t t;
        @(posedge clk);
        #2;
        // Flag follows the table as it was before this cycle
        exp_empty = (live_slots == 0);
        for (int op = 0; op < num_operands; op++) begin
            exp_operands[op].ready = 1'b1;
            exp_operands[op].tag = '0;
            if (ins.strobe && pend_valid[ins.subwarp_id][ins.src[op]]) begin
                t = pend_tag[ins.subwarp_id][ins.src[op]];
                exp_operands[op].ready = 1'b0;
                exp_operands[op].tag = t;
                // Producer completing now, ready but tag kept
                for (int w = 0; w < num_wb; w++) begin
                    if (wbs[w].strobe && wbs[w].tag == t) begin
                        exp_operands[op].ready = 1'b1;
                    end
                end
            end
        end
        insert = ins;
        wb = wbs;
        for (int w = 0; w < num_wb; w++) begin
            if (wbs[w].strobe) begin
                retire_tag(wbs[w].tag);
            end
        end
        if (ins.strobe) begin
            record_insert(ins.subwarp_id, ins.dst, ins.tag);
        end
    endtask

    task automatic directed_sequence();
        tag_t t_first;
        tag_t t_second;
        tag_t t_other;
        // Register 5 written twice, readers must wait on the newer tag
        t_first = issue_tag();
        step(make_insert(2'd0, 5'd5, t_first, 5'd1, 5'd2), '0);
        t_second = issue_tag();
        step(make_insert(2'd0, 5'd5, t_second, 5'd5, 5'd6), '0);
        t_other = issue_tag();
        step(make_insert(2'd0, 5'd7, t_other, 5'd5, 5'd5), '0);
        // Pending only in subwarp 0
        t_other = issue_tag();
        step(make_insert(2'd1, 5'd9, t_other, 5'd5, 5'd7), '0);
        // Same-cycle bypass of register 5
        t_other = issue_tag();
        step(make_insert(2'd0, 5'd8, t_other, 5'd5, 5'd7), wb_single(t_second));
        t_other = issue_tag();
        step(make_insert(2'd0, 5'd10, t_other, 5'd5, 5'd8), '0);
        // Stale producer, its entry was already reused
        step('0, wb_single(t_first));
    endtask

    task automatic random_cycle();
        wb_bus_t wbs;
        rt_insert_t ins;
        int unsigned first;
        int unsigned pick;
        wbs = '0;
        ins = '0;
        // Up to two distinct in-flight tags complete
        if (busy_tags.size() > 0 && $unsigned($random(seed)) % 3 == 0) begin
            first = $unsigned($random(seed)) % busy_tags.size();
            wbs[0] = '{strobe: 1'b1, tag: busy_tags[first]};
            if (busy_tags.size() > 1 && $unsigned($random(seed)) % 3 == 0) begin
                pick = $unsigned($random(seed)) % (busy_tags.size() - 1);
                pick = (first + 1 + pick) % busy_tags.size();
                wbs[1] = '{strobe: 1'b1, tag: busy_tags[pick]};
            end
        end
        // Few registers and subwarps, so lookups hit often
        if (free_tags.size() > 0 && $unsigned($random(seed)) % 4 != 0) begin
            ins.strobe = 1'b1;
            ins.subwarp_id = subwarp_id_t'($unsigned($random(seed)) % 2);
            ins.dst = reg_idx_t'($unsigned($random(seed)) % 6);
            ins.src[0] = reg_idx_t'($unsigned($random(seed)) % 6);
            ins.src[1] = reg_idx_t'($unsigned($random(seed)) % 6);
            // Full table without reuse, the decoder holds the insert
            if (!pend_valid[ins.subwarp_id][ins.dst] && live_slots >= num_tags) begin
                ins = '0;
            end else begin
                ins.tag = issue_tag();
            end
        end
        step(ins, wbs);
    endtask

    initial begin
        int unsigned cycles;
        wb_bus_t wbs;
        seed = 32'h273a;
        rst = 1'b1;
        insert = '0;
        wb = '0;
        exp_empty = 1'b1;
        for (int op = 0; op < num_operands; op++) begin
            exp_operands[op].ready = 1'b1;
            exp_operands[op].tag = '0;
        end
        reset_model();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        directed_sequence();
        repeat (num_random) random_cycle();

        // Retire what is still in flight, two tags per cycle
        cycles = 0;
        while (busy_tags.size() > 0 && cycles < drain_limit) begin
            wbs = wb_single(busy_tags[0]);
            if (busy_tags.size() > 1) begin
                wbs[1] = '{strobe: 1'b1, tag: busy_tags[1]};
            end
            step('0, wbs);
            cycles++;
        end

        // Empty flag rises one edge after the last clear
        cycles = 0;
        while (!all_written && cycles < drain_limit) begin
            step('0, '0);
            cycles++;
        end
        if (!all_written) begin
            abort_run("Timed out waiting for the table to drain after the last write-back");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

/* all.f */
+incdir+test
verilog/rt_pkg.sv
verilog/rt_alloc_ctrl.sv
verilog/rt_entry_store.sv
verilog/rt_operand_lookup.sv
verilog/reg_table_top.sv
test/tb_reg_table.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the register-dependency table and its testbench with
# Verilator, then run the simulation
set -e

cd "$(dirname "$0")"

# Fresh build directory
rm -rf obj_dir

verilator --binary --timing --assert \
    -f all.f \
    --top-module tb_reg_table \
    -o tb_reg_table_sim

# Exit status of the simulator is the result of the run
./obj_dir/tb_reg_table_sim
